// ==== verilog/cpu_defs_pkg.sv ====
/*
 * cpu definitions
 * shared constants and encodings for the pipeline hazard-control slice.
 * register-address width, instruction field positions, primary opcodes,
 * R-type function codes, COP0 move formats and forwarding selects
 */

package cpu_defs_pkg;

    // register file addressing, 32 GPRs
    localparam int reg_addr_w = 5;

    // low bit of each instruction field
    localparam int op_lsb = 26;     // opcode [31:26]
    localparam int rs_lsb = 21;     // rs [25:21], also COP0 format
    localparam int rt_lsb = 16;     // rt [20:16]
    localparam int rd_lsb = 11;     // rd [15:11]

    // primary opcode field
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,     // R-type, function in [5:0]
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_ADDIU   = 6'b001001,
        OP_LUI     = 6'b001111,
        OP_COP0    = 6'b010000,     // MFC0 / MTC0 by rs field
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // function field of OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,        // all-zero word is the nop
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_SLT  = 6'b101010
    } funct_e;

    // rs field of OP_COP0
    typedef enum logic [4:0] {
        COP0_MF = 5'b00000,         // mfc0, writes gpr rt
        COP0_MT = 5'b00100          // mtc0, reads gpr rt
    } cop0_fmt_e;

    // operand source for ID, nearest producer first
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,           // register file value
        FWD_EXE  = 2'b01,
        FWD_MEM  = 2'b10,
        FWD_WB   = 2'b11
    } fwd_sel_e;

endpackage

// ==== verilog/instr_decode.sv ====
/*
 * instruction decode for hazard control
 * pulls the source and destination registers out of the ID word and
 * flags which sources are really read, whether a GPR is written and
 * whether the instruction is a load
 */

`timescale 1ns/1ps

module instr_decode (
    input  logic [31:0]                         id_instr,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] id_rs,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] id_rt,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] id_dest,
    output logic [1:0]                          id_rs_rt_read,  // [1] rs, [0] rt
    output logic                                id_reg_write,
    output logic                                id_read_mem
);
    import cpu_defs_pkg::*;

    opcode_e                opcode;
    cop0_fmt_e              cop0_fmt;
    logic [reg_addr_w-1:0]  rd;

    // raw fields
    assign opcode   = opcode_e'(id_instr[op_lsb +: 6]);
    assign cop0_fmt = cop0_fmt_e'(id_instr[rs_lsb +: reg_addr_w]);
    assign id_rs    = id_instr[rs_lsb +: reg_addr_w];
    assign id_rt    = id_instr[rt_lsb +: reg_addr_w];
    assign rd       = id_instr[rd_lsb +: reg_addr_w];

    always_comb begin
        // default is an instruction that touches no GPR
        id_rs_rt_read = 2'b00;
        id_dest       = '0;
        id_reg_write  = 1'b0;
        id_read_mem   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                id_rs_rt_read = 2'b11;      // rd <- rs op rt
                id_dest       = rd;
                id_reg_write  = 1'b1;
            end
            OP_ADDIU: begin
                id_rs_rt_read = 2'b10;      // rt <- rs + imm
                id_dest       = id_rt;
                id_reg_write  = 1'b1;
            end
            OP_LW: begin
                id_rs_rt_read = 2'b10;      // base in rs
                id_dest       = id_rt;
                id_reg_write  = 1'b1;
                id_read_mem   = 1'b1;       // result only after MEM
            end
            OP_SW, OP_BEQ: begin
                id_rs_rt_read = 2'b11;      // no gpr result
            end
            OP_LUI: begin
                id_dest       = id_rt;      // immediate only
                id_reg_write  = 1'b1;
            end
            OP_COP0: begin
                if (cop0_fmt == COP0_MF) begin
                    id_dest      = id_rt;   // cp0 reg into rt
                    id_reg_write = 1'b1;
                end
                else if (cop0_fmt == COP0_MT) begin
                    id_rs_rt_read = 2'b01;  // rt into cp0 reg
                end
            end
            OP_J: begin
                id_rs_rt_read = 2'b00;      // target from immediate
            end
            default: begin
                id_rs_rt_read = 2'b00;      // unknown, treat as nop
            end
        endcase
    end

endmodule

// ==== verilog/data_hazard.sv ====
/*
 * data hazard detection
 * stalls the front end when the ID instruction needs a register that a
 * load in EXE (or in MEM, by parameter) or an MFC0 in EXE has not yet
 * produced. a stall holds pre-IF, IF and ID and puts a bubble into EXE
 */

`timescale 1ns/1ps

module data_hazard #(
    parameter bit load_mem_stall = 1'b1     // 0 lets WB forward a load in MEM
) (
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_rs,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_rt,
    input  logic [1:0]                          id_rs_rt_read,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] exe_rt,
    input  logic                                exe_read_mem,   // load in EXE
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] mem_rt,
    input  logic                                mem_read_mem,   // load in MEM
    input  logic [31:0]                         exe_instr,
    output logic                                pre_if_wr,
    output logic                                if_wr,
    output logic                                id_wr,
    output logic                                exe_flush
);
    import cpu_defs_pkg::*;

    logic exe_hit;      // ID reads EXE rt
    logic mem_hit;      // ID reads MEM rt
    logic exe_is_mfc0;

    // r0 is not excluded here, a load into $0 still stalls
    assign exe_hit = (id_rs == exe_rt && id_rs_rt_read[1]) ||
                     (id_rt == exe_rt && id_rs_rt_read[0]);
    assign mem_hit = (id_rs == mem_rt && id_rs_rt_read[1]) ||
                     (id_rt == mem_rt && id_rs_rt_read[0]);

    // mfc0 seen straight from the EXE word
    assign exe_is_mfc0 = (opcode_e'(exe_instr[op_lsb +: 6]) == OP_COP0) &&
                         (cop0_fmt_e'(exe_instr[rs_lsb +: reg_addr_w]) == COP0_MF);

    always_comb begin
        pre_if_wr = 1'b1;
        if_wr     = 1'b1;
        id_wr     = 1'b1;   // 1 lets the front end advance
        exe_flush = 1'b0;
        if (exe_read_mem && exe_hit) begin
            pre_if_wr = 1'b0;   // load-use, data not out of memory yet
            if_wr     = 1'b0;
            id_wr     = 1'b0;
            exe_flush = 1'b1;
        end
        else if (load_mem_stall && mem_read_mem && mem_hit) begin
            pre_if_wr = 1'b0;   // load still in MEM
            if_wr     = 1'b0;
            id_wr     = 1'b0;
            exe_flush = 1'b1;
        end
        else if (exe_is_mfc0 && exe_hit) begin
            pre_if_wr = 1'b0;   // cp0 value only valid after EXE
            if_wr     = 1'b0;
            id_wr     = 1'b0;
            exe_flush = 1'b1;
        end
    end

endmodule

// ==== verilog/stage_track.sv ====
/*
 * stage record tracking
 * keeps what hazard and forwarding logic need to know about the
 * instructions in EXE, MEM and WB. EXE loads the decoded ID record or a
 * bubble on flush, MEM and WB shift along every cycle
 */

`timescale 1ns/1ps

module stage_track (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                exe_flush,      // bubble into EXE
    input  logic [31:0]                         id_instr,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_rt,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_dest,
    input  logic                                id_reg_write,
    input  logic                                id_read_mem,
    output logic [31:0]                         exe_instr,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] exe_rt,
    output logic                                exe_read_mem,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] exe_dest,
    output logic                                exe_reg_write,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] mem_rt,
    output logic                                mem_read_mem,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] mem_dest,
    output logic                                mem_reg_write,
    output logic [cpu_defs_pkg::reg_addr_w-1:0] wb_dest,
    output logic                                wb_reg_write
);
    import cpu_defs_pkg::*;

    // EXE control, cleared on reset and flush
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_instr     <= '0;    // sll $0 nop, never an mfc0
            exe_read_mem  <= 1'b0;
            exe_reg_write <= 1'b0;
        end
        else if (exe_flush) begin
            exe_instr     <= '0;
            exe_read_mem  <= 1'b0;
            exe_reg_write <= 1'b0;
        end
        else begin
            exe_instr     <= id_instr;
            exe_read_mem  <= id_read_mem;
            exe_reg_write <= id_reg_write;
        end
    end

    // EXE register numbers
    // only looked at together with the flags above
    always_ff @(posedge clk) begin
        exe_rt   <= id_rt;
        exe_dest <= id_dest;
    end

    // MEM and WB control shift every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_read_mem  <= 1'b0;
            mem_reg_write <= 1'b0;
            wb_reg_write  <= 1'b0;
        end
        else begin
            mem_read_mem  <= exe_read_mem;
            mem_reg_write <= exe_reg_write;
            wb_reg_write  <= mem_reg_write;
        end
    end

    // MEM and WB register numbers
    always_ff @(posedge clk) begin
        mem_rt   <= exe_rt;     // load target for the MEM stall
        mem_dest <= exe_dest;
        wb_dest  <= mem_dest;
    end

endmodule

// ==== verilog/forward_unit.sv ====
/*
 * forwarding select
 * picks the source of each ID operand from the closest later stage that
 * writes it. EXE beats MEM beats WB, and r0 is never forwarded because
 * writes to it are dropped
 */

`timescale 1ns/1ps

module forward_unit (
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_rs,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] id_rt,
    input  logic [1:0]                          id_rs_rt_read,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] exe_dest,
    input  logic                                exe_reg_write,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] mem_dest,
    input  logic                                mem_reg_write,
    input  logic [cpu_defs_pkg::reg_addr_w-1:0] wb_dest,
    input  logic                                wb_reg_write,
    output cpu_defs_pkg::fwd_sel_e              fwd_rs_sel,
    output cpu_defs_pkg::fwd_sel_e              fwd_rt_sel
);
    import cpu_defs_pkg::*;

    // one operand, nearest producer first
    function automatic fwd_sel_e pick_src(
        input logic [reg_addr_w-1:0] src,
        input logic                  src_read
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (src_read && src != '0) begin
            if (exe_reg_write && exe_dest == src)
                sel = FWD_EXE;
            else if (mem_reg_write && mem_dest == src)
                sel = FWD_MEM;
            else if (wb_reg_write && wb_dest == src)
                sel = FWD_WB;   // same cycle as the regfile write
        end
        return sel;
    endfunction

    always_comb begin
        fwd_rs_sel = pick_src(id_rs, id_rs_rt_read[1]);
        fwd_rt_sel = pick_src(id_rt, id_rs_rt_read[0]);
    end

endmodule

// ==== verilog/pipe_ctrl_top.sv ====
/*
 * pipeline hazard control top
 * ties decode, stall detection, stage tracking and forwarding together
 * and exports the front-end write enables and operand selects
 */

`timescale 1ns/1ps

module pipe_ctrl_top #(
    parameter bit load_mem_stall = 1'b1     // stall for a load in MEM too
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            id_instr,
    output logic                   pre_if_wr,
    output logic                   if_wr,
    output logic                   id_wr,
    output cpu_defs_pkg::fwd_sel_e fwd_rs_sel,
    output cpu_defs_pkg::fwd_sel_e fwd_rt_sel
);
    import cpu_defs_pkg::*;

    // ID decode
    logic [reg_addr_w-1:0] id_rs, id_rt, id_dest;
    logic [1:0]            id_rs_rt_read;
    logic                  id_reg_write, id_read_mem;

    // stage records
    logic [31:0]           exe_instr;
    logic [reg_addr_w-1:0] exe_rt, exe_dest, mem_rt, mem_dest, wb_dest;
    logic                  exe_read_mem, exe_reg_write;
    logic                  mem_read_mem, mem_reg_write, wb_reg_write;
    logic                  exe_flush;

    instr_decode u_decode (
        .id_instr      (id_instr),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_dest       (id_dest),
        .id_rs_rt_read (id_rs_rt_read),
        .id_reg_write  (id_reg_write),
        .id_read_mem   (id_read_mem)
    );

    data_hazard #(
        .load_mem_stall (load_mem_stall)
    ) u_hazard (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_rs_rt_read (id_rs_rt_read),
        .exe_rt        (exe_rt),
        .exe_read_mem  (exe_read_mem),
        .mem_rt        (mem_rt),
        .mem_read_mem  (mem_read_mem),
        .exe_instr     (exe_instr),
        .pre_if_wr     (pre_if_wr),
        .if_wr         (if_wr),
        .id_wr         (id_wr),
        .exe_flush     (exe_flush)
    );

    stage_track u_track (
        .clk           (clk),
        .rst           (rst),
        .exe_flush     (exe_flush),
        .id_instr      (id_instr),
        .id_rt         (id_rt),
        .id_dest       (id_dest),
        .id_reg_write  (id_reg_write),
        .id_read_mem   (id_read_mem),
        .exe_instr     (exe_instr),
        .exe_rt        (exe_rt),
        .exe_read_mem  (exe_read_mem),
        .exe_dest      (exe_dest),
        .exe_reg_write (exe_reg_write),
        .mem_rt        (mem_rt),
        .mem_read_mem  (mem_read_mem),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_dest       (wb_dest),
        .wb_reg_write  (wb_reg_write)
    );

    forward_unit u_forward (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_rs_rt_read (id_rs_rt_read),
        .exe_dest      (exe_dest),
        .exe_reg_write (exe_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_dest       (wb_dest),
        .wb_reg_write  (wb_reg_write),
        .fwd_rs_sel    (fwd_rs_sel),
        .fwd_rt_sel    (fwd_rt_sel)
    );

endmodule

// ==== tb/pipe_ctrl_checker.sv ====
/*
 * checker for the hazard-control slice
 * keeps its own EXE/MEM/WB records from its own decode table and compares
 * the stall and forwarding outputs every cycle, plus the table values
 */

`timescale 1ns/1ps

module pipe_ctrl_checker #(
    parameter bit load_mem_stall = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            id_instr,
    input  logic                   pre_if_wr,
    input  logic                   if_wr,
    input  logic                   id_wr,
    input  cpu_defs_pkg::fwd_sel_e fwd_rs_sel,
    input  cpu_defs_pkg::fwd_sel_e fwd_rt_sel,
    input  bit                     exp_check,
    input  int                     exp_stalls,
    input  cpu_defs_pkg::fwd_sel_e exp_rs,
    input  cpu_defs_pkg::fwd_sel_e exp_rt,
    output int                     errors
);
    import cpu_defs_pkg::*;

    // model stage records
    logic                  ex_wr, ex_load, ex_mfc0, mem_wr, mem_load, wb_wr;
    logic [reg_addr_w-1:0] ex_dest, ex_rt, mem_dest, mem_rt, wb_dest;

    logic [reg_addr_w-1:0] rs, rt, dest;
    logic [1:0]            rd_flags;    // [1] rs read, [0] rt read
    logic                  wr, load, mfc0, hit_ex, hit_mem, stall;
    fwd_sel_e              want_rs, want_rt;
    int                    stall_cnt;

    // reads and writes by opcode
    function automatic void decode_word(input logic [31:0] w, output logic [1:0] rdf,
                                        output logic [reg_addr_w-1:0] d, output logic we,
                                        output logic ld, output logic mf);
        rdf = 2'b00;
        d   = '0;
        we  = 1'b0;
        ld  = 1'b0;
        mf  = 1'b0;
        case (w[31:26])
            OP_SPECIAL: begin
                rdf = 2'b11;
                d   = w[15:11];
                we  = 1'b1;
            end
            OP_ADDIU: begin
                rdf = 2'b10;
                d   = w[20:16];
                we  = 1'b1;
            end
            OP_LW: begin
                rdf = 2'b10;
                d   = w[20:16];
                we  = 1'b1;
                ld  = 1'b1;
            end
            OP_SW, OP_BEQ: rdf = 2'b11;
            OP_LUI: begin
                d  = w[20:16];
                we = 1'b1;
            end
            OP_COP0: begin
                if (w[25:21] == COP0_MF) begin
                    d  = w[20:16];
                    we = 1'b1;
                    mf = 1'b1;
                end
                else if (w[25:21] == COP0_MT)
                    rdf = 2'b01;
            end
            default: rdf = 2'b00;   // J and unknown
        endcase
    endfunction

    function automatic fwd_sel_e nearest(logic [reg_addr_w-1:0] src, logic rd);
        if (!rd || src == '0)
            return FWD_NONE;        // r0 never forwarded
        if (ex_wr && ex_dest == src)
            return FWD_EXE;
        if (mem_wr && mem_dest == src)
            return FWD_MEM;
        if (wb_wr && wb_dest == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        rs = id_instr[25:21];
        rt = id_instr[20:16];
        decode_word(id_instr, rd_flags, dest, wr, load, mfc0);
        hit_ex  = (rd_flags[1] && rs == ex_rt) || (rd_flags[0] && rt == ex_rt);
        hit_mem = (rd_flags[1] && rs == mem_rt) || (rd_flags[0] && rt == mem_rt);
        stall   = (ex_load && hit_ex) || (load_mem_stall && mem_load && hit_mem) ||
                  (ex_mfc0 && hit_ex);
        want_rs = nearest(rs, rd_flags[1]);
        want_rt = nearest(rt, rd_flags[0]);
    end

    // advance the model with a bubble into EXE on a stall
    always @(posedge clk) begin
        if (rst) begin
            {ex_wr, ex_load, ex_mfc0, mem_wr, mem_load, wb_wr} <= '0;
            {ex_dest, ex_rt, mem_dest, mem_rt, wb_dest} <= '0;
        end
        else begin
            wb_wr    <= mem_wr;
            wb_dest  <= mem_dest;
            mem_wr   <= ex_wr;
            mem_dest <= ex_dest;
            mem_load <= ex_load;
            mem_rt   <= ex_rt;
            ex_wr    <= wr && !stall;
            ex_load  <= load && !stall;
            ex_mfc0  <= mfc0 && !stall;
            ex_dest  <= dest;
            ex_rt    <= rt;
        end
    end

    task automatic mismatch(string what, int got, int want);
        errors = errors + 1;
        $display("FAIL %0t: %s is %0d, expected %0d, ID word %h",
                 $time, what, got, want, id_instr);
    endtask

    initial begin
        errors    = 0;
        stall_cnt = 0;
    end

    // compare mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (id_wr !== !stall)
                mismatch("id_wr", int'(id_wr), int'(!stall));
            if (pre_if_wr !== !stall)
                mismatch("pre_if_wr", int'(pre_if_wr), int'(!stall));
            if (if_wr !== !stall)
                mismatch("if_wr", int'(if_wr), int'(!stall));
            if (fwd_rs_sel !== want_rs)
                mismatch("fwd_rs_sel", int'(fwd_rs_sel), int'(want_rs));
            if (fwd_rt_sel !== want_rt)
                mismatch("fwd_rt_sel", int'(fwd_rt_sel), int'(want_rt));
            if (id_wr === 1'b1) begin
                if (exp_check) begin    // table row values at advance
                    if (stall_cnt != exp_stalls)
                        mismatch("stall cycles", stall_cnt, exp_stalls);
                    if (fwd_rs_sel !== exp_rs)
                        mismatch("table fwd_rs_sel", int'(fwd_rs_sel), int'(exp_rs));
                    if (fwd_rt_sel !== exp_rt)
                        mismatch("table fwd_rt_sel", int'(fwd_rt_sel), int'(exp_rt));
                end
                stall_cnt = 0;
            end
            else
                stall_cnt = stall_cnt + 1;
        end
    end

endmodule

// ==== tb/tb_pipe_ctrl.sv ====
/*
 * testbench for the pipeline hazard-control slice
 * drives a table of ID instruction words into the DUT, holding a word
 * while id_wr is low, with fixed cases first and random words after.
 * the checker module does all comparing
 */

`timescale 1ns/1ps

module tb_pipe_ctrl;
    import cpu_defs_pkg::*;

    localparam bit load_mem_stall = 1'b1;
    localparam int n_fixed        = 20;
    localparam int n_random       = 40;
    localparam int n_entries      = n_fixed + n_random;
    localparam int cycle_limit    = 3 * n_entries + 20;

    logic        clk;
    logic        rst;
    logic [31:0] id_instr;
    logic        pre_if_wr, if_wr, id_wr;
    fwd_sel_e    fwd_rs_sel, fwd_rt_sel;

    // per-entry stimulus plus expected values for the fixed rows
    logic [31:0] instr_tab [n_entries];
    bit          chk_tab   [n_entries];
    int          stall_tab [n_entries];   // id_wr=0 cycles before advance
    fwd_sel_e    rs_tab    [n_entries];
    fwd_sel_e    rt_tab    [n_entries];

    // what the checker compares this word against
    bit          exp_check;
    int          exp_stalls;
    fwd_sel_e    exp_rs, exp_rt;

    int          n_tab;
    int          idx;
    int          cycles;
    int          errors;
    integer      seed;

    pipe_ctrl_top #(.load_mem_stall(load_mem_stall)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .id_instr   (id_instr),
        .pre_if_wr  (pre_if_wr),
        .if_wr      (if_wr),
        .id_wr      (id_wr),
        .fwd_rs_sel (fwd_rs_sel),
        .fwd_rt_sel (fwd_rt_sel)
    );

    pipe_ctrl_checker #(.load_mem_stall(load_mem_stall)) u_checker (
        .clk        (clk),
        .rst        (rst),
        .id_instr   (id_instr),
        .pre_if_wr  (pre_if_wr),
        .if_wr      (if_wr),
        .id_wr      (id_wr),
        .fwd_rs_sel (fwd_rs_sel),
        .fwd_rt_sel (fwd_rt_sel),
        .exp_check  (exp_check),
        .exp_stalls (exp_stalls),
        .exp_rs     (exp_rs),
        .exp_rt     (exp_rt),
        .errors     (errors)
    );

    always #10 clk = ~clk;   // 20 ns period

    // instruction builders
    function automatic logic [31:0] enc_r(funct_e fn, int rs, int rt, int rd);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] enc_cop0(cop0_fmt_e fmt, int rt, int rd);
        return {OP_COP0, fmt, rt[4:0], rd[4:0], 11'd0};
    endfunction

    task automatic add_row(logic [31:0] w, bit chk, int stalls, fwd_sel_e rs, fwd_sel_e rt);
        instr_tab[n_tab] = w;
        chk_tab[n_tab]   = chk;
        stall_tab[n_tab] = stalls;
        rs_tab[n_tab]    = rs;
        rt_tab[n_tab]    = rt;
        n_tab            = n_tab + 1;
    endtask

    // random word from known opcodes with small register numbers
    function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] f;
        int          rs, rt, rd;
        r  = $random(seed);
        f  = $random(seed);
        rs = int'(f[2:0]);
        rt = int'(f[6:4]);
        rd = int'(f[10:8]);
        case (r[2:0])
            3'd0:    return enc_r(f[12] ? FN_SUBU : FN_ADDU, rs, rt, rd);
            3'd1:    return {OP_J, 26'h0000100};
            3'd2:    return enc_i(OP_BEQ, rs, rt, 4);
            3'd3:    return enc_i(OP_ADDIU, rs, rt, int'(f[31:20]));
            3'd4:    return enc_i(OP_LUI, 0, rt, 'h1234);
            3'd5:    return enc_cop0(f[13] ? COP0_MT : COP0_MF, rt, 12);
            3'd6:    return enc_i(OP_LW, rs, rt, 8);
            default: return enc_i(OP_SW, rs, rt, 12);
        endcase
    endfunction

    task automatic build_table();
        n_tab = 0;
        add_row({OP_J, 26'h0000040}, 1, 0, FWD_NONE, FWD_NONE);        // no reads after reset
        add_row(enc_i(OP_LW, 1, 5, 0), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_r(FN_ADDU, 5, 2, 6), 1, 2, FWD_WB, FWD_NONE);      // load-use costs 2 stalls
        add_row(enc_cop0(COP0_MF, 7, 12), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_i(OP_SW, 6, 7, 4), 1, 1, FWD_WB, FWD_MEM);         // mfc0-use costs 1 stall
        add_row(enc_r(FN_ADDU, 1, 1, 8), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_i(OP_ADDIU, 8, 9, 1), 1, 0, FWD_EXE, FWD_NONE);    // alu chain
        add_row(enc_r(FN_SUBU, 8, 9, 10), 1, 0, FWD_MEM, FWD_EXE);
        add_row(enc_r(FN_OR, 8, 10, 11), 1, 0, FWD_WB, FWD_EXE);
        add_row(enc_i(OP_ADDIU, 0, 12, 1), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_r(FN_ADDU, 10, 11, 12), 1, 0, FWD_WB, FWD_MEM);
        add_row(enc_r(FN_AND, 12, 12, 13), 1, 0, FWD_EXE, FWD_EXE);    // EXE beats MEM
        add_row(enc_i(OP_LW, 1, 14, 0), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_i(OP_LUI, 0, 14, 'h00ff), 1, 0, FWD_NONE, FWD_NONE);
        add_row(enc_i(OP_ADDIU, 13, 14, 2), 1, 0, FWD_WB, FWD_NONE);   // rt not read
        add_row(enc_i(OP_ADDIU, 1, 0, 5), 1, 0, FWD_NONE, FWD_NONE);   // write to r0
        add_row(enc_r(FN_ADDU, 0, 14, 15), 1, 0, FWD_NONE, FWD_MEM);
        add_row(enc_i(OP_LW, 2, 0, 0), 1, 0, FWD_NONE, FWD_NONE);      // load into r0
        add_row(enc_r(FN_ADDU, 0, 15, 16), 1, 2, FWD_NONE, FWD_NONE);  // still stalls
        add_row(enc_cop0(COP0_MT, 16, 12), 1, 0, FWD_NONE, FWD_EXE);
        for (int i = 0; i < n_random; i++)
            add_row(random_word(), 0, 0, FWD_NONE, FWD_NONE);
    endtask

    task automatic drive_entry(int k);
        id_instr   <= instr_tab[k];
        exp_check  <= chk_tab[k];
        exp_stalls <= stall_tab[k];
        exp_rs     <= rs_tab[k];
        exp_rt     <= rt_tab[k];
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        seed   = 32'haa33;
        cycles = 0;
        clk    = 1'b0;
        rst    = 1'b1;
        build_table();
        id_instr   = instr_tab[0];
        exp_check  = chk_tab[0];
        exp_stalls = stall_tab[0];
        exp_rs     = rs_tab[0];
        exp_rt     = rt_tab[0];
        idx        = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (idx < n_tab) begin
            @(posedge clk);
            if (!rst && id_wr) begin    // word accepted at this edge
                idx = idx + 1;
                if (idx < n_tab)
                    drive_entry(idx);
            end
        end
        repeat (2) @(posedge clk);
        $display("entries %0d, cycles %0d, errors %0d", n_tab, cycles, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/cpu_defs_pkg.sv
verilog/instr_decode.sv
verilog/data_hazard.sv
verilog/stage_track.sv
verilog/forward_unit.sv
verilog/pipe_ctrl_top.sv
tb/pipe_ctrl_checker.sv
tb/tb_pipe_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_pipe_ctrl
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
